//--- blur_pkg.sv
package blur_pkg;

    // image geometry, kept small for simulation
    localparam int img_width    = 16;
    localparam int img_height   = 8;
    localparam int total_pixels = img_width * img_height;

    // box kernel shape
    localparam int kernel_width = 5;
    localparam int kernel_size  = kernel_width * kernel_width;

    // four full rows plus five pixels, incoming pixel included
    localparam int buf_depth     = 4 * img_width + kernel_width;
    // first in-frame index whose window is completely filled
    localparam int fill_delay    = 4 * img_width + 4;
    // window centre sits two rows and two pixels back from the newest tap
    localparam int centre_offset = 2 * img_width + 2;

    // 5/128 stands in for 1/25
    localparam int blur_scale  = 5;
    localparam int scale_shift = 7;
    // 25 taps of 15 give 375, fits in 9 bits
    localparam int sum_w       = 9;

    // one RGB444 pixel, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb444_t;

    // stream word, seen as a bus value or as colour fields
    typedef union packed {
        logic [11:0] raw;
        rgb444_t     pix;
    } pixel_word_u;

    // tap row*5+col, tap 0 is the newest pixel
    typedef rgb444_t [kernel_size-1:0] window_t;

    // registered output beat
    typedef struct packed {
        rgb444_t pix;
        logic    sop;
        logic    eop;
        logic    valid;
    } out_beat_t;

endpackage

//--- box_blur_mac.sv
`timescale 1ns/1ps

module box_blur_mac (
    input  blur_pkg::window_t window,
    input  blur_pkg::rgb444_t centre,
    input  logic              is_underage,
    output blur_pkg::rgb444_t result
);

    // channel sum over the 25 taps
    typedef logic [blur_pkg::sum_w-1:0] sum_t;
    // sum times the coefficient, three extra bits cover the factor 5
    typedef logic [blur_pkg::sum_w+2:0] prod_t;

    sum_t r_sum;
    sum_t g_sum;
    sum_t b_sum;

    prod_t r_scl;
    prod_t g_scl;
    prod_t b_scl;

    blur_pkg::rgb444_t blurred;

    // plain adder tree, all taps carry the same weight
    always_comb begin
        r_sum = '0;
        g_sum = '0;
        b_sum = '0;
        for (int t = 0; t < blur_pkg::kernel_size; t++) begin
            r_sum = r_sum + sum_t'(window[t].r);
            g_sum = g_sum + sum_t'(window[t].g);
            b_sum = b_sum + sum_t'(window[t].b);
        end
    end

    // multiply by 5 then drop the 7 fractional bits
    // truncation, no rounding
    assign r_scl = (prod_t'(r_sum) * prod_t'(blur_pkg::blur_scale)) >> blur_pkg::scale_shift;
    assign g_scl = (prod_t'(g_sum) * prod_t'(blur_pkg::blur_scale)) >> blur_pkg::scale_shift;
    assign b_scl = (prod_t'(b_sum) * prod_t'(blur_pkg::blur_scale)) >> blur_pkg::scale_shift;

    // worst case is 375*5/128 = 14, one below the nibble limit
    always_comb begin
        assert (r_scl <= prod_t'(15) && g_scl <= prod_t'(15) && b_scl <= prod_t'(15))
            else $error("scaled channel exceeds 4 bits");
    end

    // keep the low nibble of each scaled channel
    assign blurred.r = r_scl[3:0];
    assign blurred.g = g_scl[3:0];
    assign blurred.b = b_scl[3:0];

    // blurred pixel for underage viewers, else the untouched centre
    assign result = is_underage ? blurred : centre;

endmodule

//--- dm_blurring_filter.sv
`timescale 1ns/1ps

module dm_blurring_filter (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  ready_in,
    input  logic                  valid_in,
    input  logic                  startofpacket_in,
    input  logic                  endofpacket_in,
    input  logic                  is_underage,
    input  blur_pkg::pixel_word_u data_in,
    output logic                  ready_out,
    output logic                  valid_out,
    output logic                  startofpacket_out,
    output logic                  endofpacket_out,
    output blur_pkg::pixel_word_u data_out
);

    // handshake strobe shared by buffer and framer
    logic accept;

    blur_pkg::window_t   window;
    blur_pkg::rgb444_t   centre;
    blur_pkg::rgb444_t   result;
    blur_pkg::out_beat_t out_beat;

    // no buffering of our own, backpressure goes straight upstream
    assign ready_out = ready_in;
    assign accept    = valid_in && ready_in;

    // line store and 5x5 taps
    window_shift_buffer u_buffer (
        .clk     (clk),
        .accept  (accept),
        .data_in (data_in),
        .window  (window),
        .centre  (centre)
    );

    // sum, scale and blur/bypass select, purely combinational
    box_blur_mac u_mac (
        .window      (window),
        .centre      (centre),
        .is_underage (is_underage),
        .result      (result)
    );

    // frame position, output register and flags
    stream_framer u_framer (
        .clk              (clk),
        .arst_n           (arst_n),
        .accept           (accept),
        .ready_in         (ready_in),
        .startofpacket_in (startofpacket_in),
        .endofpacket_in   (endofpacket_in),
        .result           (result),
        .out_beat         (out_beat)
    );

    // unpack the output beat onto the stream ports
    assign valid_out         = out_beat.valid;
    assign startofpacket_out = out_beat.sop;
    assign endofpacket_out   = out_beat.eop;
    assign data_out.pix      = out_beat.pix;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the blur filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log
fail_text="Simulation finished: FAIL"

verilator --binary --timing --assert -j 0 \
    --top-module tb_dm_blurring_filter \
    -f sources.f -o sim_tb > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $build_log"
    exit 1
fi

./obj_dir/sim_tb > "$sim_log" 2>&1
run_status=$?
cat "$sim_log"

if grep -q "$fail_text" "$sim_log"; then
    echo "run reported failure, see $sim_log"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
echo "run completed without failure"
exit 0

//--- sources.f
blur_pkg.sv
window_shift_buffer.sv
box_blur_mac.sv
stream_framer.sv
dm_blurring_filter.sv
tb_dm_blurring_filter.sv

//--- stream_framer.sv
`timescale 1ns/1ps

module stream_framer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                accept,
    input  logic                ready_in,
    input  logic                startofpacket_in,
    input  logic                endofpacket_in,
    input  blur_pkg::rgb444_t   result,
    output blur_pkg::out_beat_t out_beat
);

    // index range 0 to fill_delay
    typedef logic [$clog2(blur_pkg::fill_delay + 1)-1:0] idx_t;

    // in-frame index the next non-sop beat will carry, saturates
    idx_t idx_q;
    // a start of frame has been seen since reset
    logic in_frame_q;
    // first output of the frame still to be marked
    logic sop_pend_q;
    // accepted beat with a full window
    logic hit;

    // output beat registers
    blur_pkg::rgb444_t pix_q;
    logic              valid_q;
    logic              sop_q;
    logic              eop_q;

    // a sop beat has index 0 and can never produce output
    // saturation makes equality the same as index >= fill_delay
    assign hit = accept && in_frame_q && !startofpacket_in &&
                 (idx_q == idx_t'(blur_pkg::fill_delay));

    // index counter and frame tracking
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx_q      <= idx_t'(blur_pkg::fill_delay);
            in_frame_q <= 1'b0;
            sop_pend_q <= 1'b0;
        end else if (accept) begin
            if (startofpacket_in) begin
                // sop beat took index 0
                idx_q      <= idx_t'(1);
                in_frame_q <= 1'b1;
                sop_pend_q <= 1'b1;
            end else begin
                if (idx_q != idx_t'(blur_pkg::fill_delay)) begin
                    idx_q <= idx_q + idx_t'(1);
                end
                // first output of the frame has gone
                if (hit) begin
                    sop_pend_q <= 1'b0;
                end
            end
        end
    end

    // output control, frozen while downstream stalls
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            sop_q   <= 1'b0;
            eop_q   <= 1'b0;
        end else if (ready_in) begin
            valid_q <= hit;
            sop_q   <= hit && sop_pend_q;
            eop_q   <= hit && endofpacket_in;
        end
    end

    // pixel only loads on a hit, hit already implies ready_in
    always_ff @(posedge clk) begin
        if (hit) begin
            pix_q <= result;
        end
    end

    always_comb begin
        out_beat.pix   = pix_q;
        out_beat.sop   = sop_q;
        out_beat.eop   = eop_q;
        out_beat.valid = valid_q;
    end

    // frame marker only on a valid beat
    a_sop_valid : assert property (@(posedge clk) disable iff (!arst_n)
        out_beat.sop |-> out_beat.valid);

    // stalled beat keeps flags and, once valid, its pixel
    a_stall_hold : assert property (@(posedge clk) disable iff (!arst_n)
        !ready_in |=> $stable({out_beat.valid, out_beat.sop, out_beat.eop}) &&
                      (!out_beat.valid || $stable(out_beat.pix)));

    // a new frame only after the previous one filled the window
    a_frame_len : assert property (@(posedge clk) disable iff (!arst_n)
        accept && startofpacket_in && in_frame_q |->
            idx_q == idx_t'(blur_pkg::fill_delay));

endmodule

//--- tb_dm_blurring_filter.sv
`timescale 1ns/1ps

module tb_dm_blurring_filter;

    localparam int num_tests = 6;
    // beats sent before the first start of frame
    localparam int pre_beats = 20;

    // one row of the test table
    typedef struct packed {
        logic        underage;
        int          gap_pct;
        int          stall_pct;
        int          frames;
        logic [31:0] pix_seed;
    } test_row_t;

    // expected output beat, pixel plus frame flags
    typedef struct packed {
        logic [11:0] pix;
        logic        sop;
        logic        eop;
    } exp_beat_t;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  ready_in;
    logic                  valid_in;
    logic                  startofpacket_in;
    logic                  endofpacket_in;
    logic                  is_underage;
    blur_pkg::pixel_word_u data_in;
    logic                  ready_out;
    logic                  valid_out;
    logic                  startofpacket_out;
    logic                  endofpacket_out;
    blur_pkg::pixel_word_u data_out;

    string test_name [num_tests] = '{"blur_cont", "bypass_cont", "blur_gaps",
                                     "blur_stall", "blur_b2b", "bypass_mixed"};
    // underage, gap %, stall %, frames, pixel seed
    test_row_t test_table [num_tests] = '{
        '{1'b1,  0,  0, 1, 32'h0000_1a2b},
        '{1'b0,  0,  0, 1, 32'h5eed_0002},
        '{1'b1, 30,  0, 1, 32'h7c41_9e03},
        '{1'b1,  0, 30, 1, 32'h2f00_d104},
        '{1'b1,  0,  0, 2, 32'h9a9a_3105},
        '{1'b0, 25, 25, 2, 32'h0bad_c0d6}
    };

    logic [31:0] lcg_state;
    logic [31:0] pix_state;
    // every accepted pixel of the running stream
    logic [11:0] hist [2048];
    int          n_hist = 0;
    exp_beat_t   exp_q [$];
    int          errors = 0;
    int          checks = 0;
    int          outputs = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    // outputs at the previous sample, held values during a stall
    logic        prev_valid = 1'b0;
    logic        prev_sop = 1'b0;
    logic        prev_eop = 1'b0;
    logic [11:0] prev_data = 12'd0;

    dm_blurring_filter dut (
        .clk               (clk),
        .arst_n            (arst_n),
        .ready_in          (ready_in),
        .valid_in          (valid_in),
        .startofpacket_in  (startofpacket_in),
        .endofpacket_in    (endofpacket_in),
        .is_underage       (is_underage),
        .data_in           (data_in),
        .ready_out         (ready_out),
        .valid_out         (valid_out),
        .startofpacket_out (startofpacket_out),
        .endofpacket_out   (endofpacket_out),
        .data_out          (data_out)
    );

    always #4 clk = ~clk;

    // run limit, stops a stuck handshake
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // random percentage for gap and stall decisions
    function automatic int rand_pct();
        lcg_state = lcg_next(lcg_state);
        return int'(lcg_state[31:16] % 16'd100);
    endfunction

    function automatic logic [11:0] next_pixel();
        pix_state = lcg_next(pix_state);
        return pix_state[27:16];
    endfunction

    // box sum of the 5x5 neighbourhood times 5/128, or the centre pixel in bypass
    function automatic logic [11:0] model_pixel(input int i, input logic underage);
        int          rs;
        int          gs;
        int          bs;
        logic [11:0] p;
        rs = 0;
        gs = 0;
        bs = 0;
        if (!underage) begin
            return hist[i - blur_pkg::centre_offset];
        end
        for (int row = 0; row < 5; row++) begin
            for (int col = 0; col < 5; col++) begin
                p = hist[i - row * blur_pkg::img_width - col];
                rs += int'(p[11:8]);
                gs += int'(p[7:4]);
                bs += int'(p[3:0]);
            end
        end
        rs = rs * 5 / 128;
        gs = gs * 5 / 128;
        bs = bs * 5 / 128;
        return {rs[3:0], gs[3:0], bs[3:0]};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // outputs after the last rising edge, sampled mid-cycle
    task automatic sample_outputs(input logic was_ready, input logic was_hit);
        exp_beat_t e;
        check_val("ready_out", 32'(ready_out), 32'(was_ready));
        if (!was_ready) begin
            // back-pressure, everything holds
            check_val("valid_out", 32'(valid_out), 32'(prev_valid));
            check_val("startofpacket_out", 32'(startofpacket_out), 32'(prev_sop));
            check_val("endofpacket_out", 32'(endofpacket_out), 32'(prev_eop));
            if (prev_valid) begin
                check_val("data_out", 32'(data_out.raw), 32'(prev_data));
            end
        end else begin
            // output only when a beat with a full window was accepted
            check_val("valid_out", 32'(valid_out), 32'(was_hit));
            if (valid_out === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("an output appeared with nothing queued in the model at %0t",
                             $time);
                end else begin
                    e = exp_q.pop_front();
                    outputs++;
                    check_val("data_out", 32'(data_out.raw), 32'(e.pix));
                    check_val("startofpacket_out", 32'(startofpacket_out), 32'(e.sop));
                    check_val("endofpacket_out", 32'(endofpacket_out), 32'(e.eop));
                end
            end else begin
                // no output, so no frame markers either
                check_val("startofpacket_out", 32'(startofpacket_out), 32'd0);
                check_val("endofpacket_out", 32'(endofpacket_out), 32'd0);
            end
        end
        prev_valid = valid_out;
        prev_sop   = startofpacket_out;
        prev_eop   = endofpacket_out;
        prev_data  = data_out.raw;
    endtask

    // offer one pixel, retrying each cycle until the handshake completes
    task automatic drive_beat(input logic [11:0] pix, input logic sop, input logic eop,
                              input int frame_idx, input test_row_t row,
                              input logic in_frame);
        logic      accepted;
        logic      hit;
        exp_beat_t e;
        accepted = 1'b0;
        while (!accepted) begin
            valid_in         = (rand_pct() >= row.gap_pct);
            ready_in         = (rand_pct() >= row.stall_pct);
            data_in.raw      = pix;
            startofpacket_in = sop;
            endofpacket_in   = eop;
            is_underage      = row.underage;
            accepted = valid_in && ready_in;
            hit = accepted && in_frame && (frame_idx >= blur_pkg::fill_delay);
            if (accepted) begin
                hist[n_hist] = pix;
                if (hit) begin
                    e.pix = model_pixel(n_hist, row.underage);
                    e.sop = (frame_idx == blur_pkg::fill_delay);
                    e.eop = eop;
                    exp_q.push_back(e);
                end
                n_hist++;
            end
            @(negedge clk);
            sample_outputs(ready_in, hit);
        end
    endtask

    initial begin
        test_row_t idle_row;
        int        err_start;
        int        out_start;
        lcg_state        = 32'hbf2c_fca3;
        pix_state        = 32'hbf2c_fca3;
        arst_n           = 1'b0;
        ready_in         = 1'b0;
        valid_in         = 1'b0;
        startofpacket_in = 1'b0;
        endofpacket_in   = 1'b0;
        is_underage      = 1'b0;
        data_in.raw      = 12'd0;
        idle_row         = '{1'b1, 0, 0, 0, 32'd0};
        cycle_limit      = 200;
        for (int t = 0; t < num_tests; t++) begin
            cycle_limit += test_table[t].frames * blur_pkg::total_pixels * 4;
        end
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        // stream without a start of frame must give no output
        for (int k = 0; k < pre_beats; k++) begin
            drive_beat(next_pixel(), 1'b0, 1'b0, k, idle_row, 1'b0);
        end
        for (int t = 0; t < num_tests; t++) begin
            err_start = errors;
            out_start = outputs;
            pix_state = test_table[t].pix_seed;
            for (int f = 0; f < test_table[t].frames; f++) begin
                for (int p = 0; p < blur_pkg::total_pixels; p++) begin
                    drive_beat(next_pixel(), p == 0, p == blur_pkg::total_pixels - 1, p,
                               test_table[t], 1'b1);
                end
            end
            check_val("pending outputs", 32'(exp_q.size()), 32'd0);
            check_val("output count", 32'(outputs - out_start),
                      32'(test_table[t].frames * (blur_pkg::total_pixels - blur_pkg::fill_delay)));
            $display("test %0d %s: %0d outputs, %0d errors", t, test_name[t],
                     outputs - out_start, errors - err_start);
        end
        $display("tests %0d, checks %0d, outputs %0d, errors %0d",
                 num_tests, checks, outputs, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- window_shift_buffer.sv
`timescale 1ns/1ps

module window_shift_buffer (
    input  logic                  clk,
    input  logic                  accept,
    input  blur_pkg::pixel_word_u data_in,
    output blur_pkg::window_t     window,
    output blur_pkg::rgb444_t     centre
);

    // registered part of the line store
    // entry 0 is the pixel accepted just before the incoming one
    blur_pkg::rgb444_t line_q [blur_pkg::buf_depth-1];

    // line store, shifts once per accepted beat
    always_ff @(posedge clk) begin
        if (accept) begin
            // newest pixel enters at the head
            line_q[0] <= data_in.pix;
            // everything else moves one place further back
            for (int i = 1; i < blur_pkg::buf_depth - 1; i++) begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    // window taps
    // tap 0 is the incoming word itself, so the window already includes
    // the beat being accepted and the result can be registered on that edge
    for (genvar row = 0; row < blur_pkg::kernel_width; row++) begin : g_row
        for (genvar col = 0; col < blur_pkg::kernel_width; col++) begin : g_col
            if (row == 0 && col == 0) begin : g_head
                // combinational view of the beat on the bus
                assign window[0] = data_in.pix;
            end else begin : g_tap
                // stream position i - (row*16 + col)
                // one less in the register store since data_in is not stored yet
                assign window[row*blur_pkg::kernel_width+col] =
                    line_q[row*blur_pkg::img_width+col-1];
            end
        end
    end

    // centre of the 5x5 window, 34 positions back
    // used on the bypass path
    assign centre = line_q[blur_pkg::centre_offset-1];

endmodule
